/* common/ice_params.svh */
`ifndef ICE_PARAMS_SVH
`define ICE_PARAMS_SVH

// Data path widths
`define ICE_BYTE_W 8
`define ICE_PARAM_W 24

// Built-in firmware version
`define ICE_VER_MAJOR 8'h00
`define ICE_VER_MINOR 8'h04

// Command codes, ASCII
`define ICE_CMD_VER "v"
`define ICE_CMD_QI2C "I"
`define ICE_CMD_SI2C "i"
`define ICE_CMD_QGPIO "G"
`define ICE_CMD_SGPIO "g"

// Parameter selectors following the command header
`define ICE_SEL_SPEED "c"
`define ICE_SEL_ADDR "a"
`define ICE_SEL_LEVEL "l"
`define ICE_SEL_DIR "d"

`define ICE_REPLY_ACK "A"
`define ICE_REPLY_NAK "N"

`define ICE_I2C_SPEED_RST 8'd99
`define ICE_I2C_ADDR_RST 16'hFFFF

// Queue depth must be a power of two
`define ICE_QUEUE_DEPTH 16
`define ICE_MAX_REPLY 5

`endif

/* common/ice_pkg.sv */
`include "ice_params.svh"

package ice_pkg;

	// Decoder FSM states
	typedef enum logic [3:0] {
		ST_IDLE,
		ST_GET_EID,
		ST_SKIP_LEN,
		ST_GET_VER,
		ST_CHK_VER,
		ST_GET_SEL,
		ST_GET_DATA,
		ST_SEND_ACK,
		ST_SEND_NAK,
		ST_SEND_EID,
		ST_SEND_MAJ,
		ST_SEND_MIN,
		ST_SEND_VAL
	} cmd_state_e;

	typedef enum logic [2:0] {
		I2C_SPEED,
		I2C_ADDR,
		GPIO_LEVEL,
		GPIO_DIR,
		NONE
	} param_id_e;

	// One input byte plus the framing strobes
	typedef struct packed {
		logic [`ICE_BYTE_W-1:0] data;
		logic data_valid;
		logic frame_valid;
	} frame_in_t;

	// Last marks the final byte of a reply frame
	typedef struct packed {
		logic [`ICE_BYTE_W-1:0] data;
		logic last;
	} reply_byte_t;

	typedef struct packed {
		param_id_e id;
		logic shift_en;
		logic commit;
		logic [`ICE_BYTE_W-1:0] wdata;
	} param_req_t;

	typedef struct packed {
		logic [`ICE_BYTE_W-1:0] speed;
		logic [2*`ICE_BYTE_W-1:0] addr;
	} i2c_cfg_t;

	typedef struct packed {
		logic [`ICE_PARAM_W-1:0] level;
		logic [`ICE_PARAM_W-1:0] direction;
	} gpio_cfg_t;

	// Number of bytes a parameter occupies on the wire
	function automatic logic [1:0] param_bytes(param_id_e id);
		case (id)
			I2C_SPEED: param_bytes = 2'd1;
			I2C_ADDR: param_bytes = 2'd2;
			GPIO_LEVEL, GPIO_DIR: param_bytes = 2'd3;
			default: param_bytes = 2'd0;
		endcase
	endfunction

endpackage

/* cmd/cmd_decoder.sv */
`include "ice_params.svh"

module cmd_decoder (
	input logic clk,
	input logic rst,
	input ice_pkg::frame_in_t frame_in,
	input logic [`ICE_PARAM_W-1:0] rd_value,
	input logic [$clog2(`ICE_QUEUE_DEPTH):0] free_slots,
	output ice_pkg::param_req_t param_req,
	output logic push,
	output ice_pkg::reply_byte_t push_byte
);
	localparam int CNT_W = $clog2(`ICE_QUEUE_DEPTH) + 1;

	ice_pkg::cmd_state_e state, state_nxt;
	ice_pkg::param_id_e sel_id, sel_dec;
	logic fv_q;
	logic [1:0] cnt;
	logic nak_q;
	logic [`ICE_BYTE_W-1:0] cmd_q, eid_q;
	logic [2*`ICE_BYTE_W-1:0] ver_in;
	logic frame_start, code_known, is_ver, is_query, is_gpio, ver_ok;

	// New frames only when a worst-case reply is sure to fit
	assign frame_start = frame_in.frame_valid && !fv_q
		&& (free_slots >= CNT_W'(`ICE_MAX_REPLY));
	assign code_known = (frame_in.data == `ICE_CMD_VER) || (frame_in.data == `ICE_CMD_QI2C)
		|| (frame_in.data == `ICE_CMD_SI2C) || (frame_in.data == `ICE_CMD_QGPIO)
		|| (frame_in.data == `ICE_CMD_SGPIO);
	assign is_ver = (cmd_q == `ICE_CMD_VER);
	assign is_query = (cmd_q == `ICE_CMD_QI2C) || (cmd_q == `ICE_CMD_QGPIO);
	assign is_gpio = (cmd_q == `ICE_CMD_QGPIO) || (cmd_q == `ICE_CMD_SGPIO);
	assign ver_ok = (ver_in == {`ICE_VER_MAJOR, `ICE_VER_MINOR});

	// Selector meaning depends on the command group
	always_comb begin
		sel_dec = ice_pkg::NONE;
		if (is_gpio) begin
			if (frame_in.data == `ICE_SEL_LEVEL)
				sel_dec = ice_pkg::GPIO_LEVEL;
			else if (frame_in.data == `ICE_SEL_DIR)
				sel_dec = ice_pkg::GPIO_DIR;
		end else begin
			if (frame_in.data == `ICE_SEL_SPEED)
				sel_dec = ice_pkg::I2C_SPEED;
			else if (frame_in.data == `ICE_SEL_ADDR)
				sel_dec = ice_pkg::I2C_ADDR;
		end
	end

	always_comb begin
		state_nxt = state;
		push = 1'b0;
		push_byte = '0;
		param_req.id = sel_id;
		param_req.shift_en = 1'b0;
		param_req.commit = 1'b0;
		param_req.wdata = frame_in.data;
		case (state)
			ice_pkg::ST_IDLE: begin
				if (frame_start && code_known)
					state_nxt = ice_pkg::ST_GET_EID;
			end
			ice_pkg::ST_GET_EID: begin
				if (frame_in.data_valid)
					state_nxt = ice_pkg::ST_SKIP_LEN;
			end
			ice_pkg::ST_SKIP_LEN: begin
				if (frame_in.data_valid)
					state_nxt = is_ver ? ice_pkg::ST_GET_VER : ice_pkg::ST_GET_SEL;
			end
			ice_pkg::ST_GET_VER: begin
				if (frame_in.data_valid && cnt == 2'd1)
					state_nxt = ice_pkg::ST_CHK_VER;
			end
			ice_pkg::ST_CHK_VER: begin
				push = 1'b1;
				push_byte.data = ver_ok ? `ICE_REPLY_ACK : `ICE_REPLY_NAK;
				state_nxt = ice_pkg::ST_SEND_EID;
			end
			ice_pkg::ST_GET_SEL: begin
				if (frame_in.data_valid) begin
					if (sel_dec == ice_pkg::NONE)
						state_nxt = ice_pkg::ST_SEND_NAK;
					else if (is_query)
						state_nxt = ice_pkg::ST_SEND_ACK;
					else
						state_nxt = ice_pkg::ST_GET_DATA;
				end
			end
			ice_pkg::ST_GET_DATA: begin
				param_req.shift_en = frame_in.data_valid;
				if (frame_in.data_valid && cnt == 2'd1)
					state_nxt = ice_pkg::ST_SEND_ACK;
			end
			ice_pkg::ST_SEND_ACK: begin
				// A set commits together with its ACK
				param_req.commit = !is_query;
				push = 1'b1;
				push_byte.data = `ICE_REPLY_ACK;
				state_nxt = ice_pkg::ST_SEND_EID;
			end
			ice_pkg::ST_SEND_NAK: begin
				push = 1'b1;
				push_byte.data = `ICE_REPLY_NAK;
				state_nxt = ice_pkg::ST_SEND_EID;
			end
			ice_pkg::ST_SEND_EID: begin
				push = 1'b1;
				push_byte.data = eid_q;
				if (is_ver && nak_q) begin
					state_nxt = ice_pkg::ST_SEND_MAJ;
				end else if (is_query && !nak_q) begin
					state_nxt = ice_pkg::ST_SEND_VAL;
				end else begin
					push_byte.last = 1'b1;
					state_nxt = ice_pkg::ST_IDLE;
				end
			end
			ice_pkg::ST_SEND_MAJ: begin
				push = 1'b1;
				push_byte.data = `ICE_VER_MAJOR;
				state_nxt = ice_pkg::ST_SEND_MIN;
			end
			ice_pkg::ST_SEND_MIN: begin
				push = 1'b1;
				push_byte.data = `ICE_VER_MINOR;
				push_byte.last = 1'b1;
				state_nxt = ice_pkg::ST_IDLE;
			end
			ice_pkg::ST_SEND_VAL: begin
				// Most significant byte first, cnt bytes remain
				push = 1'b1;
				push_byte.data = rd_value[cnt*`ICE_BYTE_W-1 -: `ICE_BYTE_W];
				push_byte.last = (cnt == 2'd1);
				if (cnt == 2'd1)
					state_nxt = ice_pkg::ST_IDLE;
			end
			default: state_nxt = ice_pkg::ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ice_pkg::ST_IDLE;
			fv_q <= 1'b0;
			cnt <= '0;
			nak_q <= 1'b0;
			sel_id <= ice_pkg::NONE;
		end else begin
			state <= state_nxt;
			fv_q <= frame_in.frame_valid;
			if (state == ice_pkg::ST_SKIP_LEN && frame_in.data_valid)
				cnt <= 2'd2;
			else if (state == ice_pkg::ST_GET_SEL && frame_in.data_valid)
				cnt <= ice_pkg::param_bytes(sel_dec);
			else if ((state == ice_pkg::ST_GET_VER || state == ice_pkg::ST_GET_DATA)
				&& frame_in.data_valid)
				cnt <= cnt - 2'd1;
			else if (state == ice_pkg::ST_SEND_VAL)
				cnt <= cnt - 2'd1;
			if (state == ice_pkg::ST_CHK_VER)
				nak_q <= !ver_ok;
			else if (state == ice_pkg::ST_GET_SEL && frame_in.data_valid)
				nak_q <= (sel_dec == ice_pkg::NONE);
			if (state == ice_pkg::ST_GET_SEL && frame_in.data_valid)
				sel_id <= sel_dec;
		end
	end

	always_ff @(posedge clk) begin
		if (state == ice_pkg::ST_IDLE && frame_start)
			cmd_q <= frame_in.data;
		if (state == ice_pkg::ST_GET_EID && frame_in.data_valid)
			eid_q <= frame_in.data;
		if (state == ice_pkg::ST_GET_VER && frame_in.data_valid)
			ver_in <= {ver_in[`ICE_BYTE_W-1:0], frame_in.data};
	end

endmodule

/* cmd/param_regs.sv */
`include "ice_params.svh"

module param_regs (
	input logic clk,
	input logic rst,
	input ice_pkg::param_req_t param_req,
	output logic [`ICE_PARAM_W-1:0] rd_value,
	output ice_pkg::i2c_cfg_t i2c_cfg,
	output ice_pkg::gpio_cfg_t gpio_cfg
);
	localparam int ADDR_W = 2 * `ICE_BYTE_W;

	// Shadow copies collect bytes until the whole value is in
	logic [`ICE_BYTE_W-1:0] speed_sh;
	logic [ADDR_W-1:0] addr_sh;
	logic [`ICE_PARAM_W-1:0] level_sh;
	logic [`ICE_PARAM_W-1:0] dir_sh;

	always_ff @(posedge clk) begin
		if (param_req.shift_en) begin
			case (param_req.id)
				ice_pkg::I2C_SPEED: begin
					speed_sh <= param_req.wdata;
				end
				ice_pkg::I2C_ADDR: begin
					addr_sh <= {addr_sh[ADDR_W-`ICE_BYTE_W-1:0], param_req.wdata};
				end
				ice_pkg::GPIO_LEVEL: begin
					level_sh <= {level_sh[`ICE_PARAM_W-`ICE_BYTE_W-1:0], param_req.wdata};
				end
				ice_pkg::GPIO_DIR: begin
					dir_sh <= {dir_sh[`ICE_PARAM_W-`ICE_BYTE_W-1:0], param_req.wdata};
				end
				default: ;
			endcase
		end
	end

	// Live registers change only on commit
	always_ff @(posedge clk) begin
		if (rst) begin
			i2c_cfg.speed <= `ICE_I2C_SPEED_RST;
			i2c_cfg.addr <= `ICE_I2C_ADDR_RST;
			gpio_cfg.level <= '0;
			gpio_cfg.direction <= '0;
		end else if (param_req.commit) begin
			case (param_req.id)
				ice_pkg::I2C_SPEED: i2c_cfg.speed <= speed_sh;
				ice_pkg::I2C_ADDR: i2c_cfg.addr <= addr_sh;
				ice_pkg::GPIO_LEVEL: gpio_cfg.level <= level_sh;
				ice_pkg::GPIO_DIR: gpio_cfg.direction <= dir_sh;
				default: ;
			endcase
		end
	end

	// Read back the live value, right-aligned
	always_comb begin
		case (param_req.id)
			ice_pkg::I2C_SPEED: begin
				rd_value = {{(`ICE_PARAM_W-`ICE_BYTE_W){1'b0}}, i2c_cfg.speed};
			end
			ice_pkg::I2C_ADDR: begin
				rd_value = {{(`ICE_PARAM_W-ADDR_W){1'b0}}, i2c_cfg.addr};
			end
			ice_pkg::GPIO_LEVEL: begin
				rd_value = gpio_cfg.level;
			end
			ice_pkg::GPIO_DIR: begin
				rd_value = gpio_cfg.direction;
			end
			default: begin
				rd_value = '0;
			end
		endcase
	end

endmodule

/* logic/reply_queue.sv */
`include "ice_params.svh"

module reply_queue (
	input logic clk,
	input logic rst,
	input logic push,
	input ice_pkg::reply_byte_t push_byte,
	output logic [$clog2(`ICE_QUEUE_DEPTH):0] free_slots,
	output ice_pkg::reply_byte_t out_byte,
	output logic out_valid,
	input logic out_ready
);
	localparam int PTR_W = $clog2(`ICE_QUEUE_DEPTH);
	localparam int CNT_W = PTR_W + 1;
	localparam logic [CNT_W-1:0] DEPTH = CNT_W'(`ICE_QUEUE_DEPTH);

	ice_pkg::reply_byte_t mem [`ICE_QUEUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr, rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_push, do_pop;

	// A push into a full queue is dropped
	assign do_push = push && (count != DEPTH);
	assign do_pop = out_valid && out_ready;

	// Head entry stays put until it is taken
	assign out_valid = (count != '0);
	assign out_byte = mem[rd_ptr];
	assign free_slots = DEPTH - count;

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_byte;
	end

	// Pointers wrap on their own since the depth is a power of two
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end

endmodule

/* logic/basics_top.sv */
`include "ice_params.svh"

module basics_top (
	input logic clk,
	input logic rst,
	input ice_pkg::frame_in_t frame_in,
	output ice_pkg::reply_byte_t out_byte,
	output logic out_valid,
	input logic out_ready,
	output ice_pkg::i2c_cfg_t i2c_cfg,
	output ice_pkg::gpio_cfg_t gpio_cfg
);
	ice_pkg::param_req_t param_req;
	ice_pkg::reply_byte_t push_byte;
	logic [`ICE_PARAM_W-1:0] rd_value;
	logic [$clog2(`ICE_QUEUE_DEPTH):0] free_slots;
	logic push;

	cmd_decoder cmd_decoder_inst (
		.clk(clk),
		.rst(rst),
		.frame_in(frame_in),
		.rd_value(rd_value),
		.free_slots(free_slots),
		.param_req(param_req),
		.push(push),
		.push_byte(push_byte)
	);

	param_regs param_regs_inst (
		.clk(clk),
		.rst(rst),
		.param_req(param_req),
		.rd_value(rd_value),
		.i2c_cfg(i2c_cfg),
		.gpio_cfg(gpio_cfg)
	);

	// Replies leave through the queue under valid/ready
	reply_queue reply_queue_inst (
		.clk(clk),
		.rst(rst),
		.push(push),
		.push_byte(push_byte),
		.free_slots(free_slots),
		.out_byte(out_byte),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

endmodule

/* tests/basics_clkgen.sv */
module basics_clkgen (
	output logic clk
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int HALF_PERIOD = 4;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

endmodule

/* tests/basics_assertions.sv */
`include "ice_params.svh"

module basics_assertions (
	input logic clk,
	input logic rst,
	input ice_pkg::reply_byte_t out_byte,
	input logic out_valid,
	input logic out_ready
);
	timeunit 1ns;
	timeprecision 100ps;

	// Queue leaves reset empty and stays empty while held
	valid_low_in_reset: assert property (@(posedge clk) rst |=> !out_valid)
		else $error("out_valid high after a reset cycle");

	// Stalled output must not change under the consumer
	byte_stable_on_stall: assert property (@(posedge clk) disable iff (rst)
		(out_valid && !out_ready) |=> $stable(out_byte))
		else $error("out_byte changed while stalled");

	// Next frame after a last byte opens with a reply code
	frame_follows_last: assert property (@(posedge clk) disable iff (rst)
		(out_valid && out_ready && out_byte.last) |=>
		(!out_valid || out_byte.data == `ICE_REPLY_ACK || out_byte.data == `ICE_REPLY_NAK))
		else $error("Reply frame does not start with ACK or NAK");

endmodule

bind basics_top basics_assertions basics_assertions_inst (
	.clk(clk),
	.rst(rst),
	.out_byte(out_byte),
	.out_valid(out_valid),
	.out_ready(out_ready)
);

/* tests/basics_tb.sv */
`include "ice_params.svh"

module basics_tb;
	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed {
		logic [2:0] len;
		logic [4:0][`ICE_BYTE_W-1:0] data;
	} reply_t;

	// Expected output byte and cfg snapshot for set ACKs
	typedef struct packed {
		logic [`ICE_BYTE_W-1:0] data;
		logic last;
		logic chk_cfg;
		ice_pkg::i2c_cfg_t i2c;
		ice_pkg::gpio_cfg_t gpio;
	} exp_byte_t;

	logic clk, rst, out_ready, out_valid, stall_mode;
	ice_pkg::frame_in_t frame_in;
	ice_pkg::reply_byte_t out_byte;
	ice_pkg::i2c_cfg_t i2c_cfg;
	ice_pkg::gpio_cfg_t gpio_cfg;
	exp_byte_t expected [$];
	int mismatch_errs, other_errs;
	// Parameter model
	logic [7:0] speed_m;
	logic [15:0] addr_m;
	logic [23:0] level_m, dir_m;

	basics_clkgen basics_clkgen_inst (.clk(clk));

	basics_top basics_top_inst (
		.clk(clk),
		.rst(rst),
		.frame_in(frame_in),
		.out_byte(out_byte),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.i2c_cfg(i2c_cfg),
		.gpio_cfg(gpio_cfg)
	);

	function automatic int field_bytes(input logic [7:0] cmd, input logic [7:0] sel);
		if (cmd == `ICE_CMD_QI2C || cmd == `ICE_CMD_SI2C) begin
			if (sel == `ICE_SEL_SPEED)
				return 1;
			if (sel == `ICE_SEL_ADDR)
				return 2;
		end else if (cmd == `ICE_CMD_QGPIO || cmd == `ICE_CMD_SGPIO) begin
			if (sel == `ICE_SEL_LEVEL || sel == `ICE_SEL_DIR)
				return 3;
		end
		return 0;
	endfunction

	function automatic logic [23:0] model_value(input logic [7:0] sel);
		case (sel)
			`ICE_SEL_SPEED: return {16'h0, speed_m};
			`ICE_SEL_ADDR: return {8'h0, addr_m};
			`ICE_SEL_LEVEL: return level_m;
			`ICE_SEL_DIR: return dir_m;
			default: return '0;
		endcase
	endfunction

	// Expected reply frame from command, EID, payload and the model
	function automatic reply_t expected_reply(input logic [7:0] cmd, input logic [7:0] eid,
		input logic [3:0][7:0] payload);
		reply_t r;
		int nb;
		logic [23:0] val;
		r = '0;
		nb = field_bytes(cmd, payload[0]);
		val = model_value(payload[0]);
		if (cmd == `ICE_CMD_VER) begin
			r.data[1] = eid;
			if (payload[0] == `ICE_VER_MAJOR && payload[1] == `ICE_VER_MINOR) begin
				r.len = 3'd2;
				r.data[0] = `ICE_REPLY_ACK;
			end else begin
				r.len = 3'd4;
				r.data[0] = `ICE_REPLY_NAK;
				r.data[2] = `ICE_VER_MAJOR;
				r.data[3] = `ICE_VER_MINOR;
			end
		end else if (cmd == `ICE_CMD_QI2C || cmd == `ICE_CMD_SI2C
			|| cmd == `ICE_CMD_QGPIO || cmd == `ICE_CMD_SGPIO) begin
			r.data[1] = eid;
			r.len = 3'd2;
			r.data[0] = (nb == 0) ? `ICE_REPLY_NAK : `ICE_REPLY_ACK;
			if (nb != 0 && (cmd == `ICE_CMD_QI2C || cmd == `ICE_CMD_QGPIO)) begin
				r.len = 3'(2 + nb);
				for (int i = 0; i < nb; i++)
					r.data[2 + i] = val[(nb - 1 - i) * 8 +: 8];
			end
		end
		return r;
	endfunction

	task automatic update_model(input logic [7:0] cmd, input logic [3:0][7:0] payload);
		if ((cmd == `ICE_CMD_SI2C || cmd == `ICE_CMD_SGPIO)
			&& field_bytes(cmd, payload[0]) != 0) begin
			case (payload[0])
				`ICE_SEL_SPEED: speed_m = payload[1];
				`ICE_SEL_ADDR: addr_m = {payload[1], payload[2]};
				`ICE_SEL_LEVEL: level_m = {payload[1], payload[2], payload[3]};
				`ICE_SEL_DIR: dir_m = {payload[1], payload[2], payload[3]};
				default: ;
			endcase
		end
	endtask

	task automatic report_and_finish();
		$display("Error counts: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
		if (mismatch_errs == 0 && other_errs == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	endtask

	task automatic check_cfg(input ice_pkg::i2c_cfg_t exp_i2c, input ice_pkg::gpio_cfg_t exp_gpio);
		assert (i2c_cfg == exp_i2c) else begin
			$display("Mismatch i2c_cfg: expected %06h, got %06h", exp_i2c, i2c_cfg);
			mismatch_errs++;
		end
		assert (gpio_cfg == exp_gpio) else begin
			$display("Mismatch gpio_cfg: expected %012h, got %012h", exp_gpio, gpio_cfg);
			mismatch_errs++;
		end
	endtask

	task automatic compare_byte(input ice_pkg::reply_byte_t got);
		exp_byte_t e;
		assert (expected.size() != 0) else begin
			$display("Reply byte %02h arrived with no reply pending", got.data);
			other_errs++;
		end
		if (expected.size() != 0) begin
			e = expected.pop_front();
			assert (got.data == e.data) else begin
				$display("Mismatch out_byte.data: expected %02h, got %02h", e.data, got.data);
				mismatch_errs++;
			end
			assert (got.last == e.last) else begin
				$display("Mismatch out_byte.last: expected %0h, got %0h", e.last, got.last);
				mismatch_errs++;
			end
			if (e.chk_cfg)
				check_cfg(e.i2c, e.gpio);
		end
	endtask

	// Compare at the falling edge where outputs are settled
	always @(negedge clk) begin
		if (!rst && out_valid && out_ready)
			compare_byte(out_byte);
	end

	always @(posedge clk) begin
		#1;
		out_ready = stall_mode ? 1'($urandom) : 1'b1;
	end

	task automatic drive_byte(input logic [7:0] d);
		@(posedge clk);
		#1;
		frame_in.frame_valid = 1'b1;
		frame_in.data_valid = 1'b1;
		frame_in.data = d;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
			frame_in = '0;
		end
	endtask

	// Decoder finishes its pushes within the idle gap
	task automatic send_frame(input logic [7:0] cmd, input logic [7:0] eid,
		input logic [3:0][7:0] payload, input int plen);
		drive_byte(cmd);
		drive_byte(eid);
		drive_byte(8'(plen));
		for (int i = 0; i < plen; i++)
			drive_byte(payload[i]);
		idle_cycles(`ICE_MAX_REPLY + 2);
	endtask

	task automatic wait_space();
		int n;
		n = 0;
		while (expected.size() > `ICE_QUEUE_DEPTH - `ICE_MAX_REPLY && n < 1000) begin
			@(posedge clk);
			n++;
		end
		if (expected.size() > `ICE_QUEUE_DEPTH - `ICE_MAX_REPLY) begin
			$display("Timeout: reply queue never freed room for a new frame");
			other_errs++;
			expected.delete();
		end
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (expected.size() != 0 && n < 1000) begin
			@(posedge clk);
			n++;
		end
		if (expected.size() != 0) begin
			$display("Timeout: %0d reply bytes never arrived", expected.size());
			other_errs++;
			expected.delete();
		end
	endtask

	task automatic run_cmd(input logic [7:0] cmd, input logic [3:0][7:0] payload,
		input int plen, input logic chk);
		reply_t r;
		exp_byte_t e;
		logic [7:0] eid;
		eid = 8'($urandom);
		wait_space();
		r = expected_reply(cmd, eid, payload);
		update_model(cmd, payload);
		for (int i = 0; i < r.len; i++) begin
			e.data = r.data[i];
			e.last = (i == r.len - 1);
			e.chk_cfg = chk && i == 0 && (cmd == `ICE_CMD_SI2C || cmd == `ICE_CMD_SGPIO);
			e.i2c.speed = speed_m;
			e.i2c.addr = addr_m;
			e.gpio.level = level_m;
			e.gpio.direction = dir_m;
			expected.push_back(e);
		end
		send_frame(cmd, eid, payload, plen);
	endtask

	task automatic send_version(input logic [7:0] major, input logic [7:0] minor);
		run_cmd(`ICE_CMD_VER, {16'h0, minor, major}, 2, 1'b0);
	endtask

	task automatic query_param(input logic [7:0] cmd, input logic [7:0] sel);
		run_cmd(cmd, {24'h0, sel}, 1, 1'b0);
	endtask

	// Value bytes go out most significant first
	task automatic set_param(input logic [7:0] cmd, input logic [7:0] sel,
		input logic [23:0] val, input logic chk);
		logic [3:0][7:0] p;
		int nb;
		nb = field_bytes(cmd, sel);
		p = '0;
		p[0] = sel;
		for (int i = 0; i < nb; i++)
			p[1 + i] = val[(nb - 1 - i) * 8 +: 8];
		run_cmd(cmd, p, 1 + nb, chk);
	endtask

	initial begin
		void'($urandom(29534));
		rst = 1'b1;
		frame_in = '0;
		out_ready = 1'b0;
		stall_mode = 1'b0;
		mismatch_errs = 0;
		other_errs = 0;
		speed_m = `ICE_I2C_SPEED_RST;
		addr_m = `ICE_I2C_ADDR_RST;
		level_m = '0;
		dir_m = '0;
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		@(posedge clk);
		#1;
		check_cfg({`ICE_I2C_SPEED_RST, `ICE_I2C_ADDR_RST}, '0);

		// Version check, matching and not
		send_version(`ICE_VER_MAJOR, `ICE_VER_MINOR);
		wait_drain();
		send_version(`ICE_VER_MAJOR, 8'h05);
		wait_drain();
		send_version(8'($urandom) | 8'h01, 8'($urandom));
		wait_drain();

		// I2C and GPIO parameters, set then read back
		set_param(`ICE_CMD_SI2C, `ICE_SEL_SPEED, 24'($urandom), 1'b1);
		wait_drain();
		query_param(`ICE_CMD_QI2C, `ICE_SEL_SPEED);
		wait_drain();
		set_param(`ICE_CMD_SI2C, `ICE_SEL_ADDR, 24'($urandom), 1'b1);
		wait_drain();
		query_param(`ICE_CMD_QI2C, `ICE_SEL_ADDR);
		wait_drain();
		set_param(`ICE_CMD_SGPIO, `ICE_SEL_LEVEL, 24'($urandom), 1'b1);
		wait_drain();
		query_param(`ICE_CMD_QGPIO, `ICE_SEL_LEVEL);
		wait_drain();
		set_param(`ICE_CMD_SGPIO, `ICE_SEL_DIR, 24'($urandom), 1'b1);
		wait_drain();
		query_param(`ICE_CMD_QGPIO, `ICE_SEL_DIR);
		wait_drain();

		// Bad selectors, with trailing bytes on the set
		query_param(`ICE_CMD_QI2C, "x");
		wait_drain();
		run_cmd(`ICE_CMD_SGPIO, {8'h0, 8'h12, 8'h34, 8'h7a}, 3, 1'b1);
		wait_drain();
		run_cmd("q", {16'h0, 8'h55, 8'h63}, 2, 1'b0);
		wait_drain();
		assert (!out_valid) else begin
			$display("Unknown command code produced a reply");
			other_errs++;
		end
		send_version(`ICE_VER_MAJOR, `ICE_VER_MINOR);
		wait_drain();

		// Random command mix under output back-pressure
		stall_mode = 1'b1;
		for (int n = 0; n < 24; n++) begin
			case ($urandom % 7)
				0: send_version(`ICE_VER_MAJOR, `ICE_VER_MINOR);
				1: send_version(8'($urandom) | 8'h01, `ICE_VER_MINOR);
				2: query_param(`ICE_CMD_QI2C, ($urandom % 2) ? `ICE_SEL_SPEED : `ICE_SEL_ADDR);
				3: set_param(`ICE_CMD_SI2C, ($urandom % 2) ? `ICE_SEL_SPEED : `ICE_SEL_ADDR,
					24'($urandom), 1'b0);
				4: query_param(`ICE_CMD_QGPIO, ($urandom % 2) ? `ICE_SEL_LEVEL : `ICE_SEL_DIR);
				5: set_param(`ICE_CMD_SGPIO, ($urandom % 2) ? `ICE_SEL_LEVEL : `ICE_SEL_DIR,
					24'($urandom), 1'b0);
				default: query_param(`ICE_CMD_QGPIO, "z");
			endcase
		end
		wait_drain();
		stall_mode = 1'b0;
		check_cfg({speed_m, addr_m}, {level_m, dir_m});
		idle_cycles(4);
		report_and_finish();
	end

endmodule

/* sim.f */
+incdir+common
common/ice_pkg.sv
cmd/cmd_decoder.sv
cmd/param_regs.sv
logic/reply_queue.sv
logic/basics_top.sv
tests/basics_clkgen.sv
tests/basics_assertions.sv
tests/basics_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the command responder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
	--top-module basics_tb -f sim.f -Mdir obj_dir -o basics_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/basics_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q -F "*** TEST PASSED ***" sim.log; then
	exit 0
else
	exit 1
fi
